/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam int MEM_DEPTH = 2048;

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } eeprom_op_e;

    // Host sequencer. Every state except idle and finish runs whole bit periods of four quarters.
    typedef enum logic [3:0] {
        h_idle,
        h_start,
        h_send_byte,
        h_recv_ack,
        h_rstart,
        h_recv_byte,
        h_send_nack,
        h_stop,
        h_finish
    } host_state_e;

    typedef enum logic [2:0] {
        d_idle,
        d_ctrl,
        d_addr,
        d_wdata,
        d_ack,
        d_rdata,
        d_wait_mack
    } device_state_e;

endpackage

/* hdl/bus_event_detect.sv */
`timescale 1ns/1ns

module bus_event_detect (
    input  logic sda,
    input  logic rst_n,
    input  logic bus_scl,
    input  logic bus_data,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen,
    output logic data_bit
);

    // Bits 1:0 synchronize and bit 2 holds the previous synchronized level.
    logic [2:0] scl_sync;
    logic [2:0] data_sync;
    logic       scl_high;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_sync  <= '1;
            data_sync <= '1;
        end
        else
        begin
            scl_sync  <= {scl_sync[1:0], bus_scl};
            data_sync <= {data_sync[1:0], bus_data};
        end
    end

    assign scl_high   = scl_sync[1] && scl_sync[2];
    assign scl_rise   = scl_sync[1] && !scl_sync[2];
    assign scl_fall   = !scl_sync[1] && scl_sync[2];
    assign start_seen = scl_high && !data_sync[1] && data_sync[2];
    assign stop_seen  = scl_high && data_sync[1] && !data_sync[2];
    assign data_bit   = data_sync[1];

    // Start and stop stay distinct only if data never moves together with scl.
    assert property (@(posedge sda) disable iff (!rst_n)
        !((scl_sync[1] != scl_sync[2]) && (data_sync[1] != data_sync[2])));

endmodule

/* hdl/eeprom_array.sv */
`timescale 1ns/1ns

module eeprom_array
    import eeprom_pkg::*;
(
    input  logic              sda,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // Blank part reads as zero.
    initial
    begin
        for (int i = 0; i < MEM_DEPTH; i++)
            mem[i] = '0;
    end

    always @(posedge sda)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

    assert property (@(posedge sda) we |-> !$isunknown(addr));

endmodule

/* hdl/eeprom_device.sv */
`timescale 1ns/1ns

module eeprom_device
    import eeprom_pkg::*;
(
    input  logic              sda,
    input  logic              rst_n,
    input  logic              scl_rise,
    input  logic              scl_fall,
    input  logic              start_seen,
    input  logic              stop_seen,
    input  logic              data_bit,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              dev_data_low,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata
);

    device_state_e     state;
    device_state_e     ack_next;
    logic [3:0]        bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic [ADDR_W-1:0] addr_reg;
    logic              rx_state;
    logic              byte_done;
    logic              code_ok;

    assign rx_state  = state inside {d_ctrl, d_addr, d_wdata};
    // A received byte ends on the falling edge after its eighth rise.
    assign byte_done = rx_state && scl_fall && (bit_cnt == 4'd8);
    assign code_ok   = (shreg[DATA_W-1:DATA_W-4] == DEVICE_CODE);
    assign mem_addr  = addr_reg;
    assign mem_wdata = shreg;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state        <= d_idle;
            ack_next     <= d_idle;
            bit_cnt      <= '0;
            dev_data_low <= 1'b0;
            mem_we       <= 1'b0;
        end
        else
        begin
            mem_we <= 1'b0;
            if (start_seen)
            begin
                state        <= d_ctrl;
                bit_cnt      <= '0;
                dev_data_low <= 1'b0;
            end
            else if (stop_seen)
            begin
                state        <= d_idle;
                dev_data_low <= 1'b0;
            end
            else
            begin
                case (state)
                    d_ctrl, d_addr, d_wdata:
                    begin
                        if (scl_rise)
                            bit_cnt <= bit_cnt + 1'b1;
                        else if (byte_done)
                        begin
                            // Wrong device code, stay off the bus.
                            if (state == d_ctrl && !code_ok)
                                state <= d_idle;
                            else
                            begin
                                state        <= d_ack;
                                dev_data_low <= 1'b1;
                            end
                            case (state)
                                d_ctrl:  ack_next <= shreg[0] ? d_rdata : d_addr;
                                d_addr:  ack_next <= d_wdata;
                                default: ack_next <= d_idle;
                            endcase
                        end
                    end
                    d_ack:
                    begin
                        if (scl_fall)
                        begin
                            state        <= ack_next;
                            bit_cnt      <= '0;
                            dev_data_low <= (ack_next == d_rdata) && !mem_rdata[DATA_W-1];
                            // Only the write data byte acks into idle.
                            mem_we       <= (ack_next == d_idle);
                        end
                    end
                    d_rdata:
                    begin
                        if (scl_fall)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7)
                            begin
                                state        <= d_wait_mack;
                                dev_data_low <= 1'b0;
                            end
                            else
                                dev_data_low <= !shreg[DATA_W-2];
                        end
                    end
                    d_wait_mack:
                    begin
                        // NACK ends the read, an ACK waits here for the stop.
                        if (scl_rise && data_bit)
                            state <= d_idle;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (rx_state && scl_rise)
            shreg <= {shreg[DATA_W-2:0], data_bit};
        else if (state == d_ack && scl_fall && ack_next == d_rdata)
            shreg <= mem_rdata;
        else if (state == d_rdata && scl_fall)
            shreg <= {shreg[DATA_W-2:0], 1'b0};

        if (byte_done && state == d_ctrl && code_ok)
            addr_reg[ADDR_W-1:DATA_W] <= shreg[3:1];
        if (byte_done && state == d_addr)
            addr_reg[DATA_W-1:0] <= shreg;
    end

    assert property (@(posedge sda) disable iff (!rst_n) mem_we |=> !mem_we);

endmodule

/* hdl/i2c_host.sv */
`timescale 1ns/1ns

module i2c_host
    import eeprom_pkg::*;
#(
    parameter int QUARTER_CLKS = 4
) (
    input  logic              sda,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  logic              bus_scl,
    input  logic              bus_data,
    output logic              busy,
    output logic              done,
    output logic              ack_error,
    output logic [DATA_W-1:0] rdata,
    output logic              host_scl_low,
    output logic              host_data_low
);

    localparam int QW = (QUARTER_CLKS > 1) ? $clog2(QUARTER_CLKS) : 1;

    host_state_e       state;
    logic [QW-1:0]     qcnt;
    logic [1:0]        quarter;
    logic [2:0]        bit_cnt;
    logic [1:0]        byte_idx;
    eeprom_op_e        op_reg;
    logic [ADDR_W-1:0] addr_reg;
    logic [DATA_W-1:0] wdata_reg;
    logic [DATA_W-1:0] shreg;
    logic              ack_acc;
    logic              accept;
    logic              q_end;
    logic              bit_end;
    logic              sample;
    logic              scl_bit_low;

    assign accept      = (state == h_idle) && cmd_valid;
    assign q_end       = (qcnt == QW'(QUARTER_CLKS - 1));
    assign bit_end     = q_end && (quarter == 2'd3);
    // Acknowledge and read bits are taken at the end of the third quarter.
    assign sample      = q_end && (quarter == 2'd2);
    assign scl_bit_low = (quarter == 2'd0) || (quarter == 2'd3);

    // Bus drive follows the state and quarter.
    always_comb
    begin
        host_scl_low  = 1'b0;
        host_data_low = 1'b0;
        case (state)
            h_start, h_rstart:
            begin
                // Data falls in quarter 2 while scl is still high.
                host_scl_low  = scl_bit_low;
                host_data_low = quarter[1];
            end
            h_send_byte:
            begin
                host_scl_low  = scl_bit_low;
                host_data_low = ~shreg[DATA_W-1];
            end
            h_recv_ack, h_recv_byte, h_send_nack:
                host_scl_low = scl_bit_low;
            h_stop:
            begin
                // Data rises in quarter 2 with scl high.
                host_scl_low  = (quarter == 2'd0);
                host_data_low = ~quarter[1];
            end
            default: ;
        endcase
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state     <= h_idle;
            qcnt      <= '0;
            quarter   <= '0;
            bit_cnt   <= '0;
            byte_idx  <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            ack_error <= 1'b0;
            ack_acc   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == h_idle)
            begin
                qcnt    <= '0;
                quarter <= '0;
            end
            else
            begin
                qcnt <= q_end ? '0 : qcnt + 1'b1;
                if (q_end)
                    quarter <= quarter + 1'b1;
            end

            case (state)
                h_idle:
                begin
                    if (accept)
                    begin
                        state    <= h_start;
                        busy     <= 1'b1;
                        bit_cnt  <= '0;
                        byte_idx <= '0;
                        ack_acc  <= 1'b0;
                    end
                end
                h_start, h_rstart:
                begin
                    if (bit_end)
                        state <= h_send_byte;
                end
                h_send_byte:
                begin
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= h_recv_ack;
                    end
                end
                h_recv_ack:
                begin
                    if (sample && bus_data)
                        ack_acc <= 1'b1;
                    if (bit_end)
                    begin
                        case (byte_idx)
                            2'd0:
                            begin
                                state    <= h_send_byte;
                                byte_idx <= 2'd1;
                            end
                            2'd1:
                            begin
                                state    <= (op_reg == op_write) ? h_send_byte : h_rstart;
                                byte_idx <= (op_reg == op_write) ? 2'd2 : 2'd3;
                            end
                            2'd2:
                                state <= h_stop;
                            default:
                                state <= h_recv_byte;
                        endcase
                    end
                end
                h_recv_byte:
                begin
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= h_send_nack;
                    end
                end
                h_send_nack:
                begin
                    if (bit_end)
                        state <= h_stop;
                end
                h_stop:
                begin
                    if (bit_end)
                        state <= h_finish;
                end
                h_finish:
                begin
                    // One quarter of bus free time before done.
                    if (q_end)
                    begin
                        state     <= h_idle;
                        busy      <= 1'b0;
                        done      <= 1'b1;
                        ack_error <= ack_acc;
                    end
                end
                default:
                    state <= h_idle;
            endcase
        end
    end

    always_ff @(posedge sda)
    begin
        if (accept)
        begin
            op_reg    <= cmd_op;
            addr_reg  <= cmd_addr;
            wdata_reg <= cmd_wdata;
            shreg     <= {DEVICE_CODE, cmd_addr[ADDR_W-1:DATA_W], 1'b0};
        end
        else if (state == h_send_byte && bit_end)
            shreg <= {shreg[DATA_W-2:0], 1'b0};
        else if (state == h_recv_byte && sample)
            shreg <= {shreg[DATA_W-2:0], bus_data};
        else if (state == h_recv_ack && bit_end)
        begin
            // Next byte out: address, then write data or the read control byte.
            if (byte_idx == 2'd0)
                shreg <= addr_reg[DATA_W-1:0];
            else if (op_reg == op_write)
                shreg <= wdata_reg;
            else
                shreg <= {DEVICE_CODE, addr_reg[ADDR_W-1:DATA_W], 1'b1};
        end

        if (state == h_finish && q_end && op_reg == op_read)
            rdata <= shreg;
    end

    assert property (@(posedge sda) disable iff (!rst_n) done |-> $past(busy));

    // Outside start and stop conditions, data moves only under a low clock.
    assert property (@(posedge sda) disable iff (!rst_n)
        $changed(host_data_low) && !(state inside {h_start, h_rstart, h_stop}) |-> !bus_scl);

endmodule

/* hdl/eeprom_subsystem.sv */
`timescale 1ns/1ns

module eeprom_subsystem
    import eeprom_pkg::*;
#(
    parameter int QUARTER_CLKS = 4
) (
    input  logic              sda,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    output logic              busy,
    output logic              done,
    output logic              ack_error,
    output logic [DATA_W-1:0] rdata,
    output logic              bus_scl,
    output logic              bus_data
);

    logic              host_scl_low;
    logic              host_data_low;
    logic              dev_data_low;
    logic              scl_rise;
    logic              scl_fall;
    logic              start_seen;
    logic              stop_seen;
    logic              data_bit;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;

    // Open-drain lines with pull-ups, so any low drive wins.
    assign bus_scl  = ~host_scl_low;
    assign bus_data = ~(host_data_low | dev_data_low);

    i2c_host #(
        .QUARTER_CLKS (QUARTER_CLKS)
    ) host0 (
        .sda           (sda),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_addr      (cmd_addr),
        .cmd_wdata     (cmd_wdata),
        .bus_scl       (bus_scl),
        .bus_data      (bus_data),
        .busy          (busy),
        .done          (done),
        .ack_error     (ack_error),
        .rdata         (rdata),
        .host_scl_low  (host_scl_low),
        .host_data_low (host_data_low)
    );

    bus_event_detect detect0 (
        .sda        (sda),
        .rst_n      (rst_n),
        .bus_scl    (bus_scl),
        .bus_data   (bus_data),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .data_bit   (data_bit)
    );

    eeprom_device device0 (
        .sda          (sda),
        .rst_n        (rst_n),
        .scl_rise     (scl_rise),
        .scl_fall     (scl_fall),
        .start_seen   (start_seen),
        .stop_seen    (stop_seen),
        .data_bit     (data_bit),
        .mem_rdata    (mem_rdata),
        .dev_data_low (dev_data_low),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    eeprom_array array0 (
        .sda   (sda),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* test/tb_eeprom_subsystem.sv */
`timescale 1ns/1ns

module tb_eeprom_subsystem
    import eeprom_pkg::*;
();

    // About 60 transactions of at most 640 cycles, plus margin.
    localparam int MAX_TXNS       = 60;
    localparam int TXN_CYCLES     = 640;
    localparam int TIMEOUT_CYCLES = MAX_TXNS * TXN_CYCLES + 21600;

    logic              sda;
    logic              rst_n;
    logic              cmd_valid;
    eeprom_op_e        cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              busy;
    logic              done;
    logic              ack_error;
    logic [DATA_W-1:0] rdata;
    logic              bus_scl;
    logic              bus_data;

    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    bit                written [MEM_DEPTH];
    eeprom_op_e        exp_op_q [$];
    logic [DATA_W-1:0] exp_data_q [$];
    eeprom_op_e        chk_op;
    logic [DATA_W-1:0] chk_data;
    logic [31:0]       rng_state;
    int                errors;
    int                cycles;
    int                done_count;
    int                accepted_count;
    int                ack_seen;
    int                tests_passed;
    int                tests_failed;
    int                errors_at_start;

    eeprom_subsystem #(
        .QUARTER_CLKS (4)
    ) dut0 (
        .sda       (sda),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .done      (done),
        .ack_error (ack_error),
        .rdata     (rdata),
        .bus_scl   (bus_scl),
        .bus_data  (bus_data)
    );

    always #20 sda = ~sda;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        return ref_mem[addr];
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Issues one command and returns on the cycle done is seen.
    task automatic send_cmd(input eeprom_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input bit stray);
        int wait_cycles;
        if (op == op_write)
        begin
            ref_mem[addr] = wdata;
            written[addr] = 1'b1;
        end
        exp_op_q.push_back(op);
        exp_data_q.push_back(expected_read(addr));
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_wdata <= wdata;
        @(posedge sda);
        cmd_valid <= 1'b0;
        accepted_count++;
        wait_cycles = 0;
        @(posedge sda);
        while (!done)
        begin
            check_flag("busy", busy, 1'b1);
            wait_cycles++;
            // A second write to the same address while busy must be dropped.
            if (stray && wait_cycles == 20)
            begin
                cmd_valid <= 1'b1;
                cmd_op    <= op_write;
                cmd_wdata <= ~wdata;
            end
            else
                cmd_valid <= 1'b0;
            @(posedge sda);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        @(posedge sda);
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // Every done is matched against the oldest outstanding command.
    always @(posedge sda)
    begin
        if (rst_n && done)
        begin
            done_count++;
            if (ack_error)
                ack_seen++;
            if (exp_op_q.size() == 0)
            begin
                $display("done pulse arrived with no command outstanding");
                errors++;
            end
            else
            begin
                chk_op   = exp_op_q.pop_front();
                chk_data = exp_data_q.pop_front();
                check_flag("ack_error", ack_error, 1'b0);
                check_flag("busy", busy, 1'b0);
                check_flag("bus_scl", bus_scl, 1'b1);
                check_flag("bus_data", bus_data, 1'b1);
                if (chk_op == op_read)
                    check_data("rdata", rdata, chk_data);
            end
        end
    end

    always @(posedge sda)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [2:0]        blk;
        sda            = 1'b0;
        rst_n          = 1'b0;
        cmd_valid      = 1'b0;
        cmd_op         = op_write;
        cmd_addr       = '0;
        cmd_wdata      = '0;
        rng_state      = 32'hbcb168af;
        errors         = 0;
        cycles         = 0;
        done_count     = 0;
        accepted_count = 0;
        ack_seen       = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        errors_at_start = 0;
        for (int i = 0; i < MEM_DEPTH; i++)
            ref_mem[i] = '0;

        repeat (5) @(posedge sda);
        rst_n <= 1'b1;
        repeat (2) @(posedge sda);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("ack_error", ack_error, 1'b0);
        check_flag("bus_scl", bus_scl, 1'b1);
        check_flag("bus_data", bus_data, 1'b1);
        finish_test(1, "reset state");

        for (int i = 0; i < 20; i++)
        begin
            r = next_rand();
            a = r[26:16];
            d = r[7:0];
            send_cmd(op_write, a, d, 1'b0);
            send_cmd(op_read, a, 8'h00, 1'b0);
        end
        finish_test(2, "random write then read");

        for (int i = 0; i < 4; i++)
        begin
            do
            begin
                r = next_rand();
                a = r[26:16];
            end
            while (written[a]);
            send_cmd(op_read, a, 8'h00, 1'b0);
        end
        finish_test(3, "unwritten addresses read zero");

        r = next_rand();
        a = r[26:16];
        d = r[7:0];
        send_cmd(op_write, a, d, 1'b0);
        send_cmd(op_write, a, d ^ 8'h5a, 1'b0);
        send_cmd(op_read, a, 8'h00, 1'b0);
        // Blocks 0, 1, 2 and 4 touch each of address bits 10:8.
        for (int i = 0; i < 4; i++)
        begin
            blk = (i == 0) ? 3'd0 : 3'(1 << (i - 1));
            send_cmd(op_write, {blk, a[7:0]}, d + 8'(i), 1'b0);
        end
        for (int i = 0; i < 4; i++)
        begin
            blk = (i == 0) ? 3'd0 : 3'(1 << (i - 1));
            send_cmd(op_read, {blk, a[7:0]}, 8'h00, 1'b0);
        end
        finish_test(4, "overwrite and block bits");

        r = next_rand();
        a = r[26:16];
        d = r[7:0];
        send_cmd(op_write, a, d, 1'b1);
        send_cmd(op_read, a, 8'h00, 1'b0);
        @(posedge sda);
        if (done_count != accepted_count)
        begin
            $display("saw %0d done pulses for %0d accepted commands", done_count,
                     accepted_count);
            errors++;
        end
        finish_test(5, "busy gating of commands");

        r = next_rand();
        a = r[26:16];
        send_cmd(op_write, a, r[7:0], 1'b0);
        send_cmd(op_read, a, 8'h00, 1'b0);
        repeat (8) @(posedge sda);
        check_flag("bus_scl", bus_scl, 1'b1);
        check_flag("bus_data", bus_data, 1'b1);
        if (ack_seen != 0)
        begin
            $display("ack_error was set on %0d transactions", ack_seen);
            errors++;
        end
        finish_test(6, "bus idle and acknowledges");

        $display("tests passed %0d, failed %0d, check errors %0d", tests_passed,
                 tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* filelist.f */
hdl/eeprom_pkg.sv
hdl/bus_event_detect.sv
hdl/eeprom_array.sv
hdl/eeprom_device.sv
hdl/i2c_host.sv
hdl/eeprom_subsystem.sv
test/tb_eeprom_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the EEPROM subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_subsystem -f filelist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
